/* Makefile */
VERILATOR ?= verilator
TOP       := tb_frame_length_subsystem
FILELIST  := filelist.f
FLAGS     := --timing --assert
BUILD     := obj_dir
LOG       := sim.log
FAIL_MSG  := FAIL: see errors above
PASS_MSG  := PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* filelist.f */
+incdir+sim
hdl/frame_length_pkg.sv
hdl/frame_length_adjust.sv
hdl/credit_stream_tx.sv
hdl/status_queue.sv
hdl/frame_length_subsystem.sv
sim/tb_frame_length_subsystem.sv

/* hdl/credit_stream_tx.sv */
`timescale 1ns/1ps

module credit_stream_tx #(
    parameter int CREDITS = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  frame_length_pkg::axis_beat_t in_beat,
    input  logic                         in_valid,
    output logic                         in_ready,
    output frame_length_pkg::axis_beat_t m_beat,
    output logic                         m_valid,
    input  logic                         m_credit_return
);

    localparam int CW = $clog2(CREDITS + 1);

    typedef logic [CW-1:0] credit_t;

    credit_t credit_cnt;  // Credits not yet spent
    credit_t credit_next;
    logic    accept;

    ////////////////////////////////////////////////
    // Credit accounting
    ////////////////////////////////////////////////

    // A credit is spent when the beat is loaded, so the
    // output register always drains in the following cycle
    assign in_ready = (credit_cnt != '0);
    assign accept   = in_valid && in_ready;

    always_comb begin
        credit_next = credit_cnt;
        if (accept && !m_credit_return) begin
            credit_next = credit_cnt - credit_t'(1);
        end else if (!accept && m_credit_return) begin
            credit_next = credit_cnt + credit_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= credit_t'(CREDITS);
            m_valid    <= 1'b0;
        end else begin
            credit_cnt <= credit_next;
            m_valid    <= accept;  // One pulse per beat
        end
    end

    ////////////////////////////////////////////////
    // Beat register
    ////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            m_beat <= in_beat;
        end
    end

    // Downstream may only hand back credits it was given
    credit_bound: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= credit_t'(CREDITS))
        else $error("credit counter above CREDITS");

endmodule

/* hdl/frame_length_adjust.sv */
`timescale 1ns/1ps

module frame_length_adjust (
    input  logic                            clk,
    input  logic                            rst,
    input  frame_length_pkg::axis_beat_t    s_beat,
    input  logic                            s_valid,
    output logic                            s_ready,
    input  frame_length_pkg::len_t          length_min,
    input  frame_length_pkg::len_t          length_max,
    output frame_length_pkg::axis_beat_t    out_beat,
    output logic                            out_valid,
    input  logic                            out_ready,
    output frame_length_pkg::frame_status_t rec,
    output logic                            rec_valid,
    input  logic                            rec_ready
);

    localparam int NB = frame_length_pkg::DATA_BYTES;

    // Valid bytes in a contiguous keep
    function automatic frame_length_pkg::byte_count_t keep_count(
        frame_length_pkg::keep_t keep
    );
        frame_length_pkg::byte_count_t n;
        n = '0;
        for (int i = 0; i < NB; i++) begin
            n = n + frame_length_pkg::byte_count_t'(keep[i]);
        end
        return n;
    endfunction

    function automatic frame_length_pkg::keep_t keep_mask(
        frame_length_pkg::byte_count_t n
    );
        frame_length_pkg::keep_t m;
        for (int i = 0; i < NB; i++) begin
            m[i] = frame_length_pkg::byte_count_t'(i) < n;
        end
        return m;
    endfunction

    function automatic frame_length_pkg::data_t mask_data(
        frame_length_pkg::data_t data,
        frame_length_pkg::keep_t keep
    );
        frame_length_pkg::data_t d;
        for (int i = 0; i < NB; i++) begin
            d[8*i +: 8] = keep[i] ? data[8*i +: 8] : 8'h00;
        end
        return d;
    endfunction

    frame_length_pkg::adjust_state_t state;
    logic                            first;      // Next accepted beat opens a frame
    frame_length_pkg::len_t          out_cnt;
    frame_length_pkg::len_t          orig_cnt;
    logic                            pad_flag;
    logic                            trunc_flag;

    // Frame context sampled on the first beat
    frame_length_pkg::len_t                     min_q;
    frame_length_pkg::len_t                     max_q;
    logic [frame_length_pkg::ID_WIDTH-1:0]      id_q;
    logic [frame_length_pkg::DEST_WIDTH-1:0]    dest_q;
    logic [frame_length_pkg::USER_WIDTH-1:0]    user_q;

    frame_length_pkg::len_t        min_eff;
    frame_length_pkg::len_t        max_eff;
    frame_length_pkg::len_t        out_total;
    frame_length_pkg::len_t        room;
    frame_length_pkg::len_t        pad_left;
    frame_length_pkg::byte_count_t in_bytes;
    frame_length_pkg::byte_count_t out_bytes;
    frame_length_pkg::byte_count_t pad_bytes;
    frame_length_pkg::keep_t       out_keep;
    logic                          over;
    logic                          short_end;
    logic                          pad_last;

    ////////////////////////////////////////////////
    // Beat datapath
    ////////////////////////////////////////////////

    always_comb begin
        min_eff   = first ? length_min : min_q;
        max_eff   = first ? length_max : max_q;
        in_bytes  = keep_count(s_beat.keep);
        out_total = out_cnt + frame_length_pkg::len_t'(in_bytes);
        room      = max_eff - out_cnt;
        // Reaching the cap with more input to come also cuts
        over      = (out_total > max_eff) || (out_total == max_eff && !s_beat.last);
        short_end = s_beat.last && (out_total < min_eff);
        out_bytes = over ? frame_length_pkg::byte_count_t'(room) : in_bytes;

        pad_left  = min_q - out_cnt;
        pad_last  = pad_left <= frame_length_pkg::len_t'(NB);
        pad_bytes = pad_last ? frame_length_pkg::byte_count_t'(pad_left)
                             : frame_length_pkg::byte_count_t'(NB);

        out_keep      = keep_mask(state == frame_length_pkg::FRAME_PAD ? pad_bytes : out_bytes);
        out_beat.data = '0;
        out_beat.keep = out_keep;
        out_beat.last = 1'b0;
        out_beat.id   = first ? s_beat.id : id_q;
        out_beat.dest = first ? s_beat.dest : dest_q;
        out_beat.user = first ? s_beat.user : user_q;
        s_ready       = 1'b0;
        out_valid     = 1'b0;

        unique case (state)
            frame_length_pkg::FRAME_PASS: begin
                s_ready       = out_ready;
                out_valid     = s_valid;
                out_beat.data = mask_data(s_beat.data, out_keep);
                out_beat.last = over || (s_beat.last && !short_end);
            end
            frame_length_pkg::FRAME_PAD: begin
                out_valid     = 1'b1;  // Zero bytes
                out_beat.last = pad_last;
            end
            frame_length_pkg::FRAME_DROP: begin
                s_ready = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign rec.pad             = pad_flag;
    assign rec.truncate        = trunc_flag;
    assign rec.length          = out_cnt;
    assign rec.original_length = orig_cnt;

    ////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= frame_length_pkg::FRAME_IDLE;
            first      <= 1'b0;
            rec_valid  <= 1'b0;
            out_cnt    <= '0;
            orig_cnt   <= '0;
            pad_flag   <= 1'b0;
            trunc_flag <= 1'b0;
        end else begin
            unique case (state)
                frame_length_pkg::FRAME_IDLE: begin
                    // Hold here until the last record is taken
                    if (!rec_valid || rec_ready) begin
                        state      <= frame_length_pkg::FRAME_PASS;
                        first      <= 1'b1;
                        rec_valid  <= 1'b0;
                        out_cnt    <= '0;
                        orig_cnt   <= '0;
                        pad_flag   <= 1'b0;
                        trunc_flag <= 1'b0;
                    end
                end
                frame_length_pkg::FRAME_PASS: begin
                    if (s_valid && out_ready) begin
                        first    <= 1'b0;
                        out_cnt  <= out_cnt + frame_length_pkg::len_t'(out_bytes);
                        orig_cnt <= orig_cnt + frame_length_pkg::len_t'(in_bytes);
                        if (over) begin
                            trunc_flag <= 1'b1;
                            rec_valid  <= s_beat.last;
                            state      <= s_beat.last ? frame_length_pkg::FRAME_IDLE
                                                      : frame_length_pkg::FRAME_DROP;
                        end else if (short_end) begin
                            pad_flag <= 1'b1;
                            state    <= frame_length_pkg::FRAME_PAD;
                        end else if (s_beat.last) begin
                            rec_valid <= 1'b1;
                            state     <= frame_length_pkg::FRAME_IDLE;
                        end
                    end
                end
                frame_length_pkg::FRAME_PAD: begin
                    if (out_ready) begin
                        out_cnt <= out_cnt + frame_length_pkg::len_t'(pad_bytes);
                        if (pad_last) begin
                            rec_valid <= 1'b1;
                            state     <= frame_length_pkg::FRAME_IDLE;
                        end
                    end
                end
                frame_length_pkg::FRAME_DROP: begin
                    if (s_valid) begin
                        orig_cnt <= orig_cnt + frame_length_pkg::len_t'(in_bytes);
                        if (s_beat.last) begin
                            rec_valid <= 1'b1;
                            state     <= frame_length_pkg::FRAME_IDLE;
                        end
                    end
                end
                default: state <= frame_length_pkg::FRAME_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == frame_length_pkg::FRAME_PASS && first && s_valid && out_ready) begin
            min_q  <= length_min;
            max_q  <= length_max;
            id_q   <= s_beat.id;
            dest_q <= s_beat.dest;
            user_q <= s_beat.user;
        end
    end

    // Window is checked at the point it gets sampled
    window_ok: assert property (@(posedge clk) disable iff (rst)
        (state == frame_length_pkg::FRAME_PASS && first && s_valid)
            |-> (length_min != '0 && length_min <= length_max))
        else $error("length window invalid");

    // Dropping only starts once exactly length_max bytes went out
    drop_at_max: assert property (@(posedge clk) disable iff (rst)
        state == frame_length_pkg::FRAME_DROP |-> out_cnt == max_q)
        else $error("frame cut at wrong length");

endmodule

/* hdl/frame_length_pkg.sv */
package frame_length_pkg;

    ////////////////////////////////////////////////
    // Bus geometry
    ////////////////////////////////////////////////

    localparam int DATA_BYTES = 4;
    localparam int ID_WIDTH   = 8;
    localparam int DEST_WIDTH = 8;
    localparam int USER_WIDTH = 1;

    typedef logic [$clog2(DATA_BYTES + 1)-1:0] byte_count_t;  // 0 .. DATA_BYTES
    typedef logic [15:0]                       len_t;         // Frame length in bytes
    typedef logic [DATA_BYTES-1:0]             keep_t;
    typedef logic [8*DATA_BYTES-1:0]           data_t;

    typedef struct packed {
        data_t                 data;
        keep_t                 keep;
        logic                  last;
        logic [ID_WIDTH-1:0]   id;
        logic [DEST_WIDTH-1:0] dest;
        logic [USER_WIDTH-1:0] user;
    } axis_beat_t;

    // One record per frame
    typedef struct packed {
        logic pad;
        logic truncate;
        len_t length;
        len_t original_length;
    } frame_status_t;

    typedef enum logic [1:0] {
        FRAME_IDLE,
        FRAME_PASS,
        FRAME_PAD,
        FRAME_DROP
    } adjust_state_t;

endpackage

/* hdl/frame_length_subsystem.sv */
`timescale 1ns/1ps

module frame_length_subsystem #(
    parameter int CREDITS      = 4,
    parameter int STATUS_DEPTH = 2
) (
    input  logic                            clk,
    input  logic                            rst,
    input  frame_length_pkg::axis_beat_t    s_beat,
    input  logic                            s_valid,
    output logic                            s_ready,
    input  frame_length_pkg::len_t          length_min,
    input  frame_length_pkg::len_t          length_max,
    output frame_length_pkg::axis_beat_t    m_beat,
    output logic                            m_valid,
    input  logic                            m_credit_return,
    output frame_length_pkg::frame_status_t status,
    output logic                            status_valid,
    input  logic                            status_ready
);

    frame_length_pkg::axis_beat_t    out_beat;
    logic                            out_valid;
    logic                            out_ready;
    frame_length_pkg::frame_status_t rec;
    logic                            rec_valid;
    logic                            rec_ready;

    frame_length_adjust u_frame_length_adjust (
        .clk        (clk),
        .rst        (rst),
        .s_beat     (s_beat),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .length_min (length_min),
        .length_max (length_max),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .rec        (rec),
        .rec_valid  (rec_valid),
        .rec_ready  (rec_ready)
    );

    credit_stream_tx #(
        .CREDITS (CREDITS)
    ) u_credit_stream_tx (
        .clk             (clk),
        .rst             (rst),
        .in_beat         (out_beat),
        .in_valid        (out_valid),
        .in_ready        (out_ready),
        .m_beat          (m_beat),
        .m_valid         (m_valid),
        .m_credit_return (m_credit_return)
    );

    status_queue #(
        .STATUS_DEPTH (STATUS_DEPTH)
    ) u_status_queue (
        .clk          (clk),
        .rst          (rst),
        .push_rec     (rec),
        .push_valid   (rec_valid),
        .push_ready   (rec_ready),
        .status       (status),
        .status_valid (status_valid),
        .status_ready (status_ready)
    );

endmodule

/* hdl/status_queue.sv */
`timescale 1ns/1ps

module status_queue #(
    parameter int STATUS_DEPTH = 2
) (
    input  logic                            clk,
    input  logic                            rst,
    input  frame_length_pkg::frame_status_t push_rec,
    input  logic                            push_valid,
    output logic                            push_ready,
    output frame_length_pkg::frame_status_t status,
    output logic                            status_valid,
    input  logic                            status_ready
);

    localparam int PW = (STATUS_DEPTH > 1) ? $clog2(STATUS_DEPTH) : 1;
    localparam int CW = $clog2(STATUS_DEPTH + 1);

    typedef logic [PW-1:0] ptr_t;
    typedef logic [CW-1:0] count_t;

    frame_length_pkg::frame_status_t mem [STATUS_DEPTH];

    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    count_t count;
    logic   push;
    logic   pop;

    function automatic ptr_t ptr_inc(ptr_t p);
        return (p == ptr_t'(STATUS_DEPTH - 1)) ? '0 : p + ptr_t'(1);
    endfunction

    assign push_ready   = (count != count_t'(STATUS_DEPTH));
    assign status_valid = (count != '0);
    assign status       = mem[rd_ptr];
    assign push         = push_valid && push_ready;
    assign pop          = status_valid && status_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop)  rd_ptr <= ptr_inc(rd_ptr);
            if (push && !pop) begin
                count <= count + count_t'(1);
            end else if (pop && !push) begin
                count <= count - count_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_rec;
        end
    end

    // A record offered to a full queue waits unchanged for room
    push_hold: assert property (@(posedge clk) disable iff (rst)
        (push_valid && !push_ready) |=> (push_valid && $stable(push_rec)))
        else $error("record dropped at full status queue");

endmodule

/* sim/tb_frame_model.svh */
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

typedef logic [7:0] byte_q_t [$];

// Expected output, oldest first
frame_length_pkg::axis_beat_t    exp_beats [$];
frame_length_pkg::frame_status_t exp_status [$];

// Cuts a byte run into beats, keep packed from byte 0
function automatic void append_beats(
    input byte_q_t                      seg,
    input logic                         ends_frame,
    input frame_length_pkg::axis_beat_t side
);
    frame_length_pkg::axis_beat_t b;
    int                           pos;
    int                           n;
    pos = 0;
    while (pos < seg.size()) begin
        n = seg.size() - pos;
        if (n > frame_length_pkg::DATA_BYTES) begin
            n = frame_length_pkg::DATA_BYTES;
        end
        b      = side;
        b.data = '0;
        b.keep = '0;
        for (int i = 0; i < n; i++) begin
            b.data[8*i +: 8] = seg[pos + i];
            b.keep[i]        = 1'b1;
        end
        pos    = pos + n;
        b.last = ends_frame && (pos == seg.size());
        exp_beats.push_back(b);
    end
endfunction

// Input clamped to [lo, hi], short frames zero padded
function automatic frame_length_pkg::frame_status_t model_frame(
    input byte_q_t                      in_bytes,
    input int                           lo,
    input int                           hi,
    input frame_length_pkg::axis_beat_t side
);
    frame_length_pkg::frame_status_t st;
    byte_q_t                         kept;
    byte_q_t                         pad;
    int                              len;
    len = in_bytes.size();
    for (int i = 0; i < len && i < hi; i++) begin
        kept.push_back(in_bytes[i]);
    end
    for (int i = len; i < lo; i++) begin
        pad.push_back(8'h00);
    end
    // Input beats stay as they are, padding starts a fresh beat
    append_beats(kept, pad.size() == 0, side);
    append_beats(pad, 1'b1, side);
    st.pad             = (len < lo);
    st.truncate        = (len > hi);
    st.length          = frame_length_pkg::len_t'(kept.size() + pad.size());
    st.original_length = frame_length_pkg::len_t'(len);
    return st;
endfunction

`endif

/* sim/tb_frame_length_subsystem.sv */
`timescale 1ns/1ps

module tb_frame_length_subsystem;

    localparam int CREDITS      = 4;
    localparam int STATUS_DEPTH = 2;
    localparam int NUM_FRAMES   = 80;
    localparam int NB           = frame_length_pkg::DATA_BYTES;
    localparam int CYCLE_LIMIT  = 200 * NUM_FRAMES;

    logic                            clk;
    logic                            rst;
    frame_length_pkg::axis_beat_t    s_beat;
    logic                            s_valid;
    logic                            s_ready;
    frame_length_pkg::len_t          length_min;
    frame_length_pkg::len_t          length_max;
    frame_length_pkg::axis_beat_t    m_beat;
    logic                            m_valid;
    logic                            m_credit_return;
    frame_length_pkg::frame_status_t status;
    logic                            status_valid;
    logic                            status_ready;

    int beats_recv   = 0;  // Beats seen downstream
    int credits_sent = 0;  // Credit pulses driven back
    int cycles       = 0;
    int stall_left;

    `include "tb_frame_model.svh"

    frame_length_subsystem #(
        .CREDITS      (CREDITS),
        .STATUS_DEPTH (STATUS_DEPTH)
    ) u_frame_length_subsystem (
        .clk             (clk),
        .rst             (rst),
        .s_beat          (s_beat),
        .s_valid         (s_valid),
        .s_ready         (s_ready),
        .length_min      (length_min),
        .length_max      (length_max),
        .m_beat          (m_beat),
        .m_valid         (m_valid),
        .m_credit_return (m_credit_return),
        .status          (status),
        .status_valid    (status_valid),
        .status_ready    (status_ready)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_beat(
        input frame_length_pkg::axis_beat_t got,
        input frame_length_pkg::axis_beat_t want
    );
        logic ok;
        ok = (got.keep == want.keep) && (got.last == want.last) && (got.id == want.id)
            && (got.dest == want.dest) && (got.user == want.user);
        for (int i = 0; i < NB; i++) begin
            if (want.keep[i] && got.data[8*i +: 8] != want.data[8*i +: 8]) begin
                ok = 1'b0;
            end
        end
        if (!ok) begin
            abort_run($sformatf({"MISMATCH at %0t: beat %0d got data %h keep %b last %b",
                " id %h dest %h user %h, expected data %h keep %b last %b id %h dest %h",
                " user %h"}, $time, beats_recv, got.data, got.keep, got.last, got.id,
                got.dest, got.user, want.data, want.keep, want.last, want.id, want.dest,
                want.user));
        end
    endtask

    task automatic compare_status(
        input frame_length_pkg::frame_status_t got,
        input frame_length_pkg::frame_status_t want
    );
        if (got != want) begin
            abort_run($sformatf({"MISMATCH at %0t: status got pad %b trunc %b len %0d",
                " orig %0d, expected pad %b trunc %b len %0d orig %0d"}, $time, got.pad,
                got.truncate, got.length, got.original_length, want.pad, want.truncate,
                want.length, want.original_length));
        end
    endtask

    // Holds the beat until the handshake edge
    task automatic push_beat(input frame_length_pkg::axis_beat_t b);
        logic done;
        s_beat  = b;
        s_valid = 1'b1;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = s_ready;
            @(posedge clk);
            #1;
        end
        s_valid = 1'b0;
    endtask

    // Kind 0 random, 1 inside the window, 2 short, 3 long
    task automatic choose_frame(input int kind, output int len, output int lo, output int hi);
        case (kind)
            1: begin
                lo  = $urandom_range(20, 1);
                hi  = lo + $urandom_range(20, 0);
                len = $urandom_range(hi, lo);
            end
            2: begin
                lo  = $urandom_range(40, 2);
                hi  = lo + $urandom_range(8, 0);
                len = $urandom_range(lo - 1, 1);
            end
            3: begin
                hi  = $urandom_range(39, 1);
                lo  = $urandom_range(hi, 1);
                len = $urandom_range(40, hi + 1);
            end
            default: begin
                lo  = $urandom_range(24, 1);
                hi  = lo + $urandom_range(16, 0);
                len = $urandom_range(40, 1);
            end
        endcase
    endtask

    ////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////

    initial begin
        byte_q_t                      frame;
        frame_length_pkg::axis_beat_t side;
        frame_length_pkg::axis_beat_t b;
        int                           len;
        int                           lo;
        int                           hi;
        int                           n;

        void'($urandom(32'h6f0b6ef0));
        rst        = 1'b1;
        s_valid    = 1'b0;
        s_beat     = '0;
        length_min = 16'd1;
        length_max = 16'd1;
        repeat (10) @(posedge clk);
        #1;
        if (s_ready !== 1'b0 || m_valid !== 1'b0 || status_valid !== 1'b0) begin
            abort_run("outputs not idle at the end of reset");
        end
        rst = 1'b0;

        for (int f = 0; f < NUM_FRAMES; f++) begin
            choose_frame(f % 4, len, lo, hi);
            side      = '0;
            side.id   = 8'($urandom);
            side.dest = 8'($urandom);
            side.user = 1'($urandom);
            frame.delete();
            for (int i = 0; i < len; i++) begin
                frame.push_back(8'($urandom));
            end
            exp_status.push_back(model_frame(frame, lo, hi, side));
            length_min = frame_length_pkg::len_t'(lo);
            length_max = frame_length_pkg::len_t'(hi);
            for (int k = 0; k < len; k += NB) begin
                if ($urandom_range(3, 0) == 0) begin
                    repeat ($urandom_range(3, 1)) @(posedge clk);
                    #1;
                end
                n = (len - k < NB) ? len - k : NB;
                b = side;
                if (k != 0) begin  // Later sideband must be ignored
                    b.id   = 8'($urandom);
                    b.dest = 8'($urandom);
                    b.user = 1'($urandom);
                end
                b.data = frame_length_pkg::data_t'($urandom);  // Junk above keep
                b.keep = '0;
                for (int i = 0; i < n; i++) begin
                    b.data[8*i +: 8] = frame[k + i];
                    b.keep[i]        = 1'b1;
                end
                b.last = (k + NB >= len);
                push_beat(b);
            end
        end

        while (exp_beats.size() != 0 || exp_status.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);  // Room for a stray beat
        $display("PASS: all tests");
        $finish;
    end

    ////////////////////////////////////////////////
    // Downstream and status consumer
    ////////////////////////////////////////////////

    initial begin
        m_credit_return = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (beats_recv > credits_sent && $urandom_range(2, 0) == 0) begin
                m_credit_return = 1'b1;
                credits_sent    = credits_sent + 1;
            end else begin
                m_credit_return = 1'b0;
            end
        end
    end

    initial begin
        status_ready = 1'b0;
        stall_left   = 0;
        forever begin
            @(posedge clk);
            #1;
            if (stall_left > 0) begin
                status_ready = 1'b0;
                stall_left   = stall_left - 1;
            end else if ($urandom_range(15, 0) == 0) begin
                status_ready = 1'b0;
                stall_left   = $urandom_range(30, 5);  // Long stall fills the queue
            end else begin
                status_ready = ($urandom_range(3, 0) != 0);
            end
        end
    end

    // Inputs only change after the rising edge
    always @(negedge clk) begin : compare_outputs
        frame_length_pkg::axis_beat_t    want_beat;
        frame_length_pkg::frame_status_t want_status;
        if (!rst && m_valid) begin
            if (exp_beats.size() == 0) begin
                abort_run("output beat arrived with no frame pending");
            end else begin
                want_beat = exp_beats.pop_front();
                compare_beat(m_beat, want_beat);
                beats_recv = beats_recv + 1;
                if (beats_recv - credits_sent > CREDITS) begin
                    abort_run($sformatf("more than %0d beats outstanding at time %0t",
                        CREDITS, $time));
                end
            end
        end
        if (!rst && status_valid && status_ready) begin
            if (exp_status.size() == 0) begin
                abort_run("status record arrived with no frame pending");
            end else begin
                want_status = exp_status.pop_front();
                compare_status(status, want_status);
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            abort_run($sformatf("timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

endmodule
